/* hw/cache_pkg.sv */
// shared widths, line type, FSM states and the byte merge helper for the cache hierarchy
`default_nettype none

package cache_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int OFFSET_W   = 2;
    localparam int LINE_WORDS = 1 << OFFSET_W;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [WORD_W/8-1:0] strb_t;
    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t; // word 0 in the low bits

    typedef enum logic [2:0] {
        L1_IDLE,
        L1_MISS_REQ,
        L1_MISS_WAIT,
        L1_WRITE_REQ,
        L1_WRITE_WAIT
    } l1_state_e;

    typedef enum logic [2:0] {
        L2_IDLE,
        L2_LOOKUP,
        L2_MRD_REQ,
        L2_MRD_WAIT,
        L2_MWR_REQ,
        L2_MWR_WAIT,
        L2_RESP
    } l2_state_e;

    typedef enum logic {
        SRC_I,
        SRC_D
    } l2_src_e;

    // bytes with strobe set come from new_w
    function automatic word_t merge_word(word_t old_w, word_t new_w, strb_t strb);
        word_t res;
        res = old_w;
        for (int b = 0; b < WORD_W / 8; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

/* hw/cache_req_if.sv */
// one L1-to-L2 request channel (req/addr_ok/data_ok handshake), one instance per L1 cache
`default_nettype none

interface cache_req_if;
    import cache_pkg::*;

    logic  req;
    logic  we;
    word_t addr;
    word_t wdata;
    strb_t wstrb;
    logic  addr_ok; // request consumed this cycle
    logic  data_ok; // one-cycle response pulse
    line_t rdata;

    modport l1 (
        output req, we, addr, wdata, wstrb,
        input  addr_ok, data_ok, rdata
    );

    modport l2 (
        input  req, we, addr, wdata, wstrb,
        output addr_ok, data_ok, rdata
    );

endinterface

`default_nettype wire

/* hw/icache.sv */
// direct-mapped L1 instruction cache, returns one word per fetch and refills lines from L2
`default_nettype none

module icache #(
    parameter int INDEX_W = 2
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             if_valid,
    input  cache_pkg::word_t if_addr,
    output logic             if_ready,
    output cache_pkg::word_t if_rdata,
    output logic             if_rvalid,
    cache_req_if.l1          l2
);
    import cache_pkg::*;

    localparam int LINES = 1 << INDEX_W;
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - 2;

    logic [LINES-1:0] valid_q;
    logic [TAG_W-1:0] tags [LINES];
    line_t            lines [LINES];

    l1_state_e           state_q;
    logic                lookup_q; // tag check cycle after acceptance
    word_t               addr_q;
    logic [INDEX_W-1:0]  idx;
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] off;
    logic                hit;

    assign idx = addr_q[OFFSET_W+2 +: INDEX_W];
    assign tag = addr_q[ADDR_W-1 -: TAG_W];
    assign off = addr_q[2 +: OFFSET_W];
    assign hit = valid_q[idx] && (tags[idx] == tag);

    assign if_ready  = (state_q == L1_IDLE) && !lookup_q;
    assign if_rvalid = (lookup_q && hit) || ((state_q == L1_MISS_WAIT) && l2.data_ok);
    assign if_rdata  = (state_q == L1_MISS_WAIT) ? l2.rdata[off] : lines[idx][off];

    // read-only side of the channel
    assign l2.req   = (lookup_q && !hit) || (state_q == L1_MISS_REQ);
    assign l2.we    = 1'b0;
    assign l2.addr  = addr_q;
    assign l2.wdata = '0;
    assign l2.wstrb = '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= L1_IDLE;
            lookup_q <= 1'b0;
            valid_q  <= '0;
        end else begin
            lookup_q <= if_valid && if_ready;
            case (state_q)
                L1_IDLE: begin
                    if (lookup_q && !hit) begin
                        state_q <= l2.addr_ok ? L1_MISS_WAIT : L1_MISS_REQ;
                    end
                end
                L1_MISS_REQ: begin
                    if (l2.addr_ok) begin
                        state_q <= L1_MISS_WAIT;
                    end
                end
                L1_MISS_WAIT: begin
                    if (l2.data_ok) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= L1_IDLE;
                    end
                end
                default: state_q <= L1_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && if_ready) begin
            addr_q <= if_addr;
        end
        if ((state_q == L1_MISS_WAIT) && l2.data_ok) begin // refill
            lines[idx] <= l2.rdata;
            tags[idx]  <= tag;
        end
    end

endmodule

`default_nettype wire

/* hw/dcache.sv */
// direct-mapped write-through L1 data cache, word reads and byte-strobed writes through to L2
`default_nettype none

module dcache #(
    parameter int INDEX_W = 2
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             d_valid,
    input  logic             d_we,
    input  cache_pkg::word_t d_addr,
    input  cache_pkg::word_t d_wdata,
    input  cache_pkg::strb_t d_wstrb,
    output logic             d_ready,
    output cache_pkg::word_t d_rdata,
    output logic             d_resp_valid,
    cache_req_if.l1          l2
);
    import cache_pkg::*;

    localparam int LINES = 1 << INDEX_W;
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - 2;

    logic [LINES-1:0] valid_q;
    logic [TAG_W-1:0] tags [LINES];
    line_t            lines [LINES];

    l1_state_e           state_q;
    logic                lookup_q;
    logic                we_q;
    word_t               addr_q;
    word_t               wdata_q;
    strb_t               wstrb_q;
    logic [INDEX_W-1:0]  idx;
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] off;
    logic                hit;
    logic                wait_ack;

    assign idx = addr_q[OFFSET_W+2 +: INDEX_W];
    assign tag = addr_q[ADDR_W-1 -: TAG_W];
    assign off = addr_q[2 +: OFFSET_W];
    assign hit = valid_q[idx] && (tags[idx] == tag);

    assign wait_ack = (state_q == L1_MISS_WAIT) || (state_q == L1_WRITE_WAIT);

    assign d_ready      = (state_q == L1_IDLE) && !lookup_q;
    assign d_resp_valid = (lookup_q && !we_q && hit) || (wait_ack && l2.data_ok);
    assign d_rdata      = (state_q == L1_MISS_WAIT) ? l2.rdata[off] : lines[idx][off];

    // writes always go down, reads only on a miss
    assign l2.req   = (lookup_q && (we_q || !hit))
                      || (state_q == L1_MISS_REQ) || (state_q == L1_WRITE_REQ);
    assign l2.we    = we_q;
    assign l2.addr  = addr_q;
    assign l2.wdata = wdata_q;
    assign l2.wstrb = wstrb_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q  <= L1_IDLE;
            lookup_q <= 1'b0;
            valid_q  <= '0;
        end else begin
            lookup_q <= d_valid && d_ready;
            case (state_q)
                L1_IDLE: begin
                    if (lookup_q && we_q) begin
                        state_q <= l2.addr_ok ? L1_WRITE_WAIT : L1_WRITE_REQ;
                    end else if (lookup_q && !hit) begin
                        state_q <= l2.addr_ok ? L1_MISS_WAIT : L1_MISS_REQ;
                    end
                end
                L1_MISS_REQ: begin
                    if (l2.addr_ok) begin
                        state_q <= L1_MISS_WAIT;
                    end
                end
                L1_MISS_WAIT: begin
                    if (l2.data_ok) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= L1_IDLE;
                    end
                end
                L1_WRITE_REQ: begin
                    if (l2.addr_ok) begin
                        state_q <= L1_WRITE_WAIT;
                    end
                end
                L1_WRITE_WAIT: begin
                    if (l2.data_ok) begin
                        state_q <= L1_IDLE; // L2 ack ends the write
                    end
                end
                default: state_q <= L1_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (d_valid && d_ready) begin
            we_q    <= d_we;
            addr_q  <= d_addr;
            wdata_q <= d_wdata;
            wstrb_q <= d_wstrb;
        end
        if (lookup_q && we_q && hit) begin // no-write-allocate, hit only
            lines[idx][off] <= merge_word(lines[idx][off], wdata_q, wstrb_q);
        end
        if ((state_q == L1_MISS_WAIT) && l2.data_ok) begin
            lines[idx] <= l2.rdata;
            tags[idx]  <= tag;
        end
    end

endmodule

`default_nettype wire

/* hw/l2cache.sv */
// shared direct-mapped write-through L2, arbitrates the two L1 channels and drives main memory
`default_nettype none

module l2cache #(
    parameter int INDEX_W = 3
) (
    input  logic             clk,
    input  logic             arst_n,
    cache_req_if.l2          i_port,
    cache_req_if.l2          d_port,
    output logic             mem_req,
    output logic             mem_we,
    output cache_pkg::word_t mem_addr,
    output cache_pkg::word_t mem_wdata,
    output cache_pkg::strb_t mem_wstrb,
    input  logic             mem_addr_ok,
    input  cache_pkg::line_t mem_rdata,
    input  logic             mem_data_ok
);
    import cache_pkg::*;

    localparam int LINES = 1 << INDEX_W;
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W - 2;

    logic [LINES-1:0] valid_q;
    logic [TAG_W-1:0] tags [LINES];
    line_t            lines [LINES];

    l2_state_e           state_q;
    l2_src_e             src_q;
    logic                we_q;
    word_t               addr_q;
    word_t               wdata_q;
    strb_t               wstrb_q;
    logic [INDEX_W-1:0]  idx;
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] off;
    logic                hit;
    logic                idle;

    assign idx  = addr_q[OFFSET_W+2 +: INDEX_W];
    assign tag  = addr_q[ADDR_W-1 -: TAG_W];
    assign off  = addr_q[2 +: OFFSET_W];
    assign hit  = valid_q[idx] && (tags[idx] == tag);
    assign idle = (state_q == L2_IDLE);

    // fixed priority, data side first
    assign d_port.addr_ok = idle && d_port.req;
    assign i_port.addr_ok = idle && i_port.req && !d_port.req;

    assign d_port.data_ok = (state_q == L2_RESP) && (src_q == SRC_D);
    assign i_port.data_ok = (state_q == L2_RESP) && (src_q == SRC_I);
    assign d_port.rdata   = lines[idx];
    assign i_port.rdata   = lines[idx];

    assign mem_req   = (state_q == L2_MRD_REQ) || (state_q == L2_MWR_REQ);
    assign mem_we    = (state_q == L2_MWR_REQ);
    assign mem_addr  = mem_we ? addr_q : {addr_q[ADDR_W-1:OFFSET_W+2], {(OFFSET_W + 2){1'b0}}};
    assign mem_wdata = wdata_q;
    assign mem_wstrb = wstrb_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= L2_IDLE;
            src_q   <= SRC_I;
            valid_q <= '0;
        end else begin
            case (state_q)
                L2_IDLE: begin
                    if (d_port.req) begin
                        src_q   <= SRC_D;
                        state_q <= L2_LOOKUP;
                    end else if (i_port.req) begin
                        src_q   <= SRC_I;
                        state_q <= L2_LOOKUP;
                    end
                end
                L2_LOOKUP: begin
                    if (we_q) begin
                        state_q <= L2_MWR_REQ;
                    end else if (hit) begin
                        state_q <= L2_RESP;
                    end else begin
                        state_q <= L2_MRD_REQ;
                    end
                end
                L2_MRD_REQ: begin
                    if (mem_addr_ok) begin
                        state_q <= L2_MRD_WAIT;
                    end
                end
                L2_MRD_WAIT: begin
                    if (mem_data_ok) begin
                        valid_q[idx] <= 1'b1;
                        state_q      <= L2_RESP;
                    end
                end
                L2_MWR_REQ: begin
                    if (mem_addr_ok) begin
                        state_q <= L2_MWR_WAIT;
                    end
                end
                L2_MWR_WAIT: begin
                    if (mem_data_ok) begin
                        state_q <= L2_RESP; // memory is current now
                    end
                end
                default: state_q <= L2_IDLE; // L2_RESP lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (d_port.addr_ok) begin
            we_q    <= d_port.we;
            addr_q  <= d_port.addr;
            wdata_q <= d_port.wdata;
            wstrb_q <= d_port.wstrb;
        end else if (i_port.addr_ok) begin
            we_q    <= i_port.we;
            addr_q  <= i_port.addr;
            wdata_q <= i_port.wdata;
            wstrb_q <= i_port.wstrb;
        end
        if ((state_q == L2_LOOKUP) && we_q && hit) begin
            lines[idx][off] <= merge_word(lines[idx][off], wdata_q, wstrb_q);
        end
        if ((state_q == L2_MRD_WAIT) && mem_data_ok) begin
            lines[idx] <= mem_rdata;
            tags[idx]  <= tag;
        end
    end

endmodule

`default_nettype wire

/* hw/l1_l2_cache.sv */
// cache subsystem top, connects the two L1 caches to the shared L2 and exposes the memory port
`default_nettype none

module l1_l2_cache #(
    parameter int I_INDEX_W  = 2,
    parameter int D_INDEX_W  = 2,
    parameter int L2_INDEX_W = 3
) (
    input  logic             clk,
    input  logic             arst_n,

    // instruction fetch side
    input  logic             if_valid,
    input  cache_pkg::word_t if_addr,
    output logic             if_ready,
    output cache_pkg::word_t if_rdata,
    output logic             if_rvalid,

    // load/store side
    input  logic             d_valid,
    input  logic             d_we,
    input  cache_pkg::word_t d_addr,
    input  cache_pkg::word_t d_wdata,
    input  cache_pkg::strb_t d_wstrb,
    output logic             d_ready,
    output cache_pkg::word_t d_rdata,
    output logic             d_resp_valid,

    // main memory, line reads and word writes
    output logic             mem_req,
    output logic             mem_we,
    output cache_pkg::word_t mem_addr,
    output cache_pkg::word_t mem_wdata,
    output cache_pkg::strb_t mem_wstrb,
    input  logic             mem_addr_ok,
    input  cache_pkg::line_t mem_rdata,
    input  logic             mem_data_ok
);

    cache_req_if i_chan ();
    cache_req_if d_chan ();

    icache #(
        .INDEX_W (I_INDEX_W)
    ) u_icache (
        .clk       (clk),
        .arst_n    (arst_n),
        .if_valid  (if_valid),
        .if_addr   (if_addr),
        .if_ready  (if_ready),
        .if_rdata  (if_rdata),
        .if_rvalid (if_rvalid),
        .l2        (i_chan.l1)
    );

    dcache #(
        .INDEX_W (D_INDEX_W)
    ) u_dcache (
        .clk          (clk),
        .arst_n       (arst_n),
        .d_valid      (d_valid),
        .d_we         (d_we),
        .d_addr       (d_addr),
        .d_wdata      (d_wdata),
        .d_wstrb      (d_wstrb),
        .d_ready      (d_ready),
        .d_rdata      (d_rdata),
        .d_resp_valid (d_resp_valid),
        .l2           (d_chan.l1)
    );

    l2cache #(
        .INDEX_W (L2_INDEX_W)
    ) u_l2cache (
        .clk         (clk),
        .arst_n      (arst_n),
        .i_port      (i_chan.l2),
        .d_port      (d_chan.l2),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_rdata   (mem_rdata),
        .mem_data_ok (mem_data_ok)
    );

endmodule

`default_nettype wire

/* sim/mem_model.sv */
// behavioral main memory for the cache testbench, answers line reads and strobed word writes
`default_nettype none

module mem_model #(
    parameter int WORDS = 1024
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             mem_req,
    input  logic             mem_we,
    input  cache_pkg::word_t mem_addr,
    input  cache_pkg::word_t mem_wdata,
    input  cache_pkg::strb_t mem_wstrb,
    output logic             mem_addr_ok,
    output cache_pkg::line_t mem_rdata,
    output logic             mem_data_ok
);
    timeunit 1ns;
    timeprecision 1ps;
    import cache_pkg::*;

    localparam int AW = $clog2(WORDS);

    typedef enum logic [2:0] {
        M_IDLE,
        M_ADDR,
        M_ACK,
        M_DATA,
        M_DONE
    } phase_e;

    word_t       mem [WORDS];
    phase_e      phase;
    logic [1:0]  cnt;
    logic [31:0] seed;
    word_t       addr_q;

    function automatic logic [31:0] lcg_step(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= word_t'(i * 4) ^ 32'h5a5a_0000;
            end
            phase       <= M_IDLE;
            cnt         <= '0;
            seed        <= 32'hc90b08e3;
            addr_q      <= '0;
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
        end else begin
            case (phase)
                M_IDLE: begin
                    if (mem_req) begin
                        seed  <= lcg_step(seed);
                        cnt   <= 2'(lcg_step(seed) >> 30); // 1 to 4 cycles before addr_ok
                        phase <= M_ADDR;
                    end
                end
                M_ADDR: begin
                    if (cnt == 0) begin
                        mem_addr_ok <= 1'b1;
                        phase       <= M_ACK;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                M_ACK: begin
                    // request consumed at this edge
                    mem_addr_ok <= 1'b0;
                    addr_q      <= mem_addr;
                    if (mem_we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (mem_wstrb[b]) begin
                                mem[mem_addr[AW+1:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
                            end
                        end
                    end
                    seed  <= lcg_step(seed);
                    cnt   <= 2'(lcg_step(seed) >> 30);
                    phase <= M_DATA;
                end
                M_DATA: begin
                    if (cnt == 0) begin
                        for (int k = 0; k < LINE_WORDS; k++) begin
                            mem_rdata[k] <= mem[{addr_q[AW+1:4], 2'(k)}];
                        end
                        mem_data_ok <= 1'b1;
                        phase       <= M_DONE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    mem_data_ok <= 1'b0; // one-cycle pulse
                    phase       <= M_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* sim/tb_l1_l2_cache.sv */
// directed testbench for the L1/L2 cache subsystem, checks every response against a shadow memory
`default_nettype none

module tb_l1_l2_cache;
    timeunit 1ns;
    timeprecision 1ps;
    import cache_pkg::*;

    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT   = 400;

    logic  clk;
    logic  arst_n;
    logic  if_valid;
    word_t if_addr;
    logic  if_ready;
    word_t if_rdata;
    logic  if_rvalid;
    logic  d_valid;
    logic  d_we;
    word_t d_addr;
    word_t d_wdata;
    strb_t d_wstrb;
    logic  d_ready;
    word_t d_rdata;
    logic  d_resp_valid;
    logic  mem_req;
    logic  mem_we;
    word_t mem_addr;
    word_t mem_wdata;
    strb_t mem_wstrb;
    logic  mem_addr_ok;
    line_t mem_rdata;
    logic  mem_data_ok;

    word_t       shadow [MEM_WORDS];
    logic [31:0] rand_state;
    int          error_cnt      = 0;
    int          tests_run      = 0;
    int          tests_failed   = 0;
    int          mem_req_cycles = 0;

    l1_l2_cache #(
        .I_INDEX_W  (2),
        .D_INDEX_W  (2),
        .L2_INDEX_W (3)
    ) u_l1_l2_cache (
        .clk          (clk),
        .arst_n       (arst_n),
        .if_valid     (if_valid),
        .if_addr      (if_addr),
        .if_ready     (if_ready),
        .if_rdata     (if_rdata),
        .if_rvalid    (if_rvalid),
        .d_valid      (d_valid),
        .d_we         (d_we),
        .d_addr       (d_addr),
        .d_wdata      (d_wdata),
        .d_wstrb      (d_wstrb),
        .d_ready      (d_ready),
        .d_rdata      (d_rdata),
        .d_resp_valid (d_resp_valid),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_wstrb    (mem_wstrb),
        .mem_addr_ok  (mem_addr_ok),
        .mem_rdata    (mem_rdata),
        .mem_data_ok  (mem_data_ok)
    );

    mem_model #(
        .WORDS (MEM_WORDS)
    ) u_mem_model (
        .clk         (clk),
        .arst_n      (arst_n),
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_addr_ok (mem_addr_ok),
        .mem_rdata   (mem_rdata),
        .mem_data_ok (mem_data_ok)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (mem_req === 1'b1) begin
            mem_req_cycles++; // memory traffic seen by the tests
            if (mem_we === 1'b0) begin
                // line reads go out line-aligned
                compare_word("mem_addr[3:0] on line read", mem_addr & 32'hf, 32'h0);
            end
        end
    end

    function automatic word_t next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // word-aligned address inside the modelled 4 KiB
    function automatic word_t rand_addr();
        word_t r;
        r = next_rand();
        return {20'h0, r[29:20], 2'b00};
    endfunction

    function automatic word_t expected(word_t addr);
        return shadow[addr[11:2]];
    endfunction

    function automatic void shadow_write(word_t addr, word_t data, strb_t strb);
        word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        shadow[addr[11:2]] = (shadow[addr[11:2]] & ~mask) | (data & mask);
    endfunction

    task automatic abort_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
                 error_cnt);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
            error_cnt++;
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
            error_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests_run++;
        if (error_cnt == errs_at_start) begin
            $display("test %-12s ok", name);
        end else begin
            tests_failed++;
            $display("test %-12s %0d errors", name, error_cnt - errs_at_start);
        end
    endtask

    // lat counts cycles from acceptance to if_rvalid
    task automatic fetch(input word_t addr, output word_t data, output int lat);
        int n;
        @(posedge clk);
        if_valid <= 1'b1;
        if_addr  <= addr;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!if_ready && n < TIMEOUT);
        if (!if_ready) begin
            abort_run($sformatf("if_ready stayed low, fetch of %h never accepted", addr));
        end
        @(posedge clk); // accepted here
        if_valid <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!if_rvalid && lat < TIMEOUT);
        if (!if_rvalid) begin
            abort_run($sformatf("no if_rvalid for fetch of %h", addr));
        end
        data = if_rdata;
    endtask

    task automatic d_access(input logic we, input word_t addr, input word_t wdata,
                            input strb_t strb, output word_t data, output int lat);
        int n;
        @(posedge clk);
        d_valid <= 1'b1;
        d_we    <= we;
        d_addr  <= addr;
        d_wdata <= wdata;
        d_wstrb <= strb;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!d_ready && n < TIMEOUT);
        if (!d_ready) begin
            abort_run($sformatf("d_ready stayed low, access to %h never accepted", addr));
        end
        @(posedge clk);
        d_valid <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!d_resp_valid && lat < TIMEOUT);
        if (!d_resp_valid) begin
            abort_run($sformatf("no d_resp_valid for access to %h", addr));
        end
        data = d_rdata;
    endtask

    task automatic read_and_check(input word_t addr);
        word_t data;
        int    lat;
        d_access(1'b0, addr, '0, '0, data, lat);
        compare_word($sformatf("d_rdata[%h]", addr), data, expected(addr));
    endtask

    task automatic fetch_and_check(input word_t addr);
        word_t data;
        int    lat;
        fetch(addr, data, lat);
        compare_word($sformatf("if_rdata[%h]", addr), data, expected(addr));
    endtask

    task automatic write_word(input word_t addr, input word_t data, input strb_t strb);
        word_t unused;
        int    lat;
        d_access(1'b1, addr, data, strb, unused, lat);
        shadow_write(addr, data, strb);
    endtask

    task automatic reset_outputs();
        int errs0;
        errs0 = error_cnt;
        @(negedge clk);
        compare_bit("if_ready", if_ready, 1'b1);
        compare_bit("d_ready", d_ready, 1'b1);
        compare_bit("if_rvalid", if_rvalid, 1'b0);
        compare_bit("d_resp_valid", d_resp_valid, 1'b0);
        compare_bit("mem_req", mem_req, 1'b0);
        finish_test("reset", errs0);
    endtask

    task automatic fetch_miss_then_hit();
        int    errs0;
        int    req0;
        int    lat;
        word_t data;
        word_t addr;
        errs0 = error_cnt;
        addr  = 32'h0000_0104;
        req0  = mem_req_cycles;
        fetch(addr, data, lat);
        compare_word($sformatf("if_rdata[%h]", addr), data, expected(addr));
        compare_bit("mem_req on first fetch", mem_req_cycles != req0, 1'b1);
        req0 = mem_req_cycles;
        fetch(addr, data, lat); // now a hit
        compare_word($sformatf("if_rdata[%h]", addr), data, expected(addr));
        compare_bit("if_rvalid one cycle after accept", lat == 1, 1'b1);
        compare_bit("mem_req on second fetch", mem_req_cycles != req0, 1'b0);
        finish_test("fetch", errs0);
    endtask

    task automatic data_reads();
        int errs0;
        errs0 = error_cnt;
        read_and_check(32'h0000_0100); // line already in the icache
        read_and_check(32'h0000_0108);
        read_and_check(32'h0000_010c);
        for (int i = 0; i < 12; i++) begin
            read_and_check(rand_addr());
        end
        finish_test("data_reads", errs0);
    endtask

    task automatic strobe_writes();
        int    errs0;
        word_t a;
        word_t b;
        errs0 = error_cnt;
        a     = 32'h0000_0200;
        b     = 32'h0000_0344;
        read_and_check(a); // bring the line into L1
        write_word(a, 32'hdead_beef, 4'b0101);
        read_and_check(a);
        read_and_check(a + 32'h40); // same L1 index only, line stays in L2
        read_and_check(a);          // merged word now served by L2
        read_and_check(a + 32'h80); // same L1 and L2 index, evicts both
        read_and_check(a);
        write_word(b, 32'hcafe_f00d, 4'b1110);
        read_and_check(b);
        read_and_check(b + 32'h4);
        finish_test("strobe_wr", errs0);
    endtask

    task automatic conflict_reads();
        int    errs0;
        word_t bases [4];
        errs0    = error_cnt;
        bases[0] = 32'h0000_0400;
        bases[1] = 32'h0000_0440; // L1 conflict
        bases[2] = 32'h0000_0480; // L1 and L2 conflict
        bases[3] = 32'h0000_04c0;
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 4; k++) begin
                read_and_check(bases[k] + word_t'(4 * r));
                fetch_and_check(bases[k] + 32'h8);
            end
        end
        finish_test("conflicts", errs0);
    endtask

    task automatic concurrent_reads();
        int    errs0;
        word_t ia;
        word_t da;
        word_t idata;
        word_t ddata;
        int    ilat;
        int    dlat;
        errs0 = error_cnt;
        for (int i = 0; i < 10; i++) begin
            ia = rand_addr();
            da = rand_addr();
            fork
                fetch(ia, idata, ilat);
                d_access(1'b0, da, '0, '0, ddata, dlat);
            join
            compare_word($sformatf("if_rdata[%h]", ia), idata, expected(ia));
            compare_word($sformatf("d_rdata[%h]", da), ddata, expected(da));
        end
        finish_test("concurrent", errs0);
    endtask

    initial begin
        arst_n     = 1'b0;
        if_valid   = 1'b0;
        if_addr    = '0;
        d_valid    = 1'b0;
        d_we       = 1'b0;
        d_addr     = '0;
        d_wdata    = '0;
        d_wstrb    = '0;
        rand_state = 32'hc90b08e3;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = word_t'(i * 4) ^ 32'h5a5a_0000;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        reset_outputs();
        fetch_miss_then_hit();
        data_reads();
        strobe_writes();
        conflict_reads();
        concurrent_reads();

        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
                 error_cnt);
        if (tests_failed == 0 && error_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hw/cache_pkg.sv
hw/cache_req_if.sv
hw/icache.sv
hw/dcache.sv
hw/l2cache.sv
hw/l1_l2_cache.sv
sim/mem_model.sv
sim/tb_l1_l2_cache.sv

/* Bender.yml */
package:
  name: l1_l2_cache

sources:
  - hw/cache_pkg.sv
  - hw/cache_req_if.sv
  - hw/icache.sv
  - hw/dcache.sv
  - hw/l2cache.sv
  - hw/l1_l2_cache.sv
  - target: simulation
    files:
      - sim/mem_model.sv
      - sim/tb_l1_l2_cache.sv
